//--- Bender.yml
package:
  name: mf_window

export_include_dirs:
  - include

sources:
  - files:
      - hw/mf_pkg.sv
      - hw/mf_pos_decode.sv
      - hw/mf_window_shift.sv
      - hw/mf_pad_mask.sv
      - hw/mf_window_top.sv
  - target: simulation
    files:
      - sim/mf_window_chk.sv
      - sim/mf_window_scoreboard.sv
      - sim/mf_window_tb.sv

//--- hw/mf_pad_mask.sv
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_pad_mask (
    input  logic             clk,
    input  logic             rst,
    input  mf_pkg::win_ctl_t ctl_i,
    input  mf_pkg::window_t  win_i,
    output logic             win_valid_o,
    output mf_pkg::window_t  win_o,
    output logic             frame_done_o
);

    mf_pkg::window_t win_masked;

    // a pixel survives only if both its row and its column are inside the image
    always_comb begin
        for (int j = 0; j < `MF_WIN; j++) begin
            for (int i = 0; i < `MF_WIN; i++) begin
                if (ctl_i.row_ok[i] && ctl_i.col_ok[j]) begin
                    win_masked.col[j].px[i] = win_i.col[j].px[i];
                end else begin
                    win_masked.col[j].px[i] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid_o  <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            win_valid_o  <= ctl_i.valid;
            frame_done_o <= ctl_i.valid && ctl_i.last;
        end
    end

    // window only loads with a valid control word, holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            win_o <= '0;
        end else if (ctl_i.valid) begin
            win_o <= win_masked;
        end
    end

endmodule

//--- hw/mf_pkg.sv
`include "mf_consts.svh"

package mf_pkg;

    typedef logic [`MF_PIX_W-1:0] pixel_t;
    typedef logic [`MF_POS_W-1:0] pos_t;

    // bit k set when window row or column k lies inside the image
    typedef logic [`MF_WIN-1:0] lane_mask_t;

    // one column of the window, px[k] is window row k, px[2] the centre line
    typedef struct packed {
        pixel_t [`MF_WIN-1:0] px;
    } col_slice_t;

    // col[0] is the oldest column, col[4] the newest, col[2] the centre
    typedef struct packed {
        col_slice_t [`MF_WIN-1:0] col;
    } window_t;

    // control word from position decode to the mask stage
    typedef struct packed {
        logic       valid;
        lane_mask_t row_ok;
        lane_mask_t col_ok;
        logic       last;
    } win_ctl_t;

    // warm-up FSM, two slices are absorbed before the first window
    typedef enum logic [1:0] {
        FILL0,
        FILL1,
        RUN
    } fill_state_t;

endpackage

//--- hw/mf_pos_decode.sv
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_pos_decode #(
    parameter int ROWS = `MF_ROWS_DEF,
    parameter int COLS = `MF_COLS_DEF
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             col_valid_i,
    output mf_pkg::win_ctl_t ctl_o
);

    localparam int HALF = `MF_WIN / 2;

    mf_pkg::fill_state_t state;
    mf_pkg::pos_t        row;
    mf_pkg::pos_t        col;
    mf_pkg::lane_mask_t  row_ok;
    mf_pkg::lane_mask_t  col_ok;
    logic                last_pix;
    logic                col_wrap;

    // the window needs at least a full 5x5 image to have sane borders
    if (ROWS < `MF_WIN || COLS < `MF_WIN) begin : g_size_check
        $error("mf_pos_decode: image must be at least %0d x %0d", `MF_WIN, `MF_WIN);
    end

    // lanes below the centre need distance to the low edge,
    // lanes above it need distance to the high edge
    function automatic mf_pkg::lane_mask_t edge_mask(
        input mf_pkg::pos_t pos,
        input mf_pkg::pos_t last_pos
    );
        mf_pkg::pos_t       to_end;
        mf_pkg::lane_mask_t m;
        to_end = last_pos - pos;
        for (int k = 0; k < `MF_WIN; k++) begin
            if (k < HALF) begin
                m[k] = (pos >= mf_pkg::pos_t'(HALF - k));
            end else begin
                m[k] = (to_end >= mf_pkg::pos_t'(k - HALF));
            end
        end
        return m;
    endfunction

    always_comb begin
        row_ok   = edge_mask(row, mf_pkg::pos_t'(ROWS - 1));
        col_ok   = edge_mask(col, mf_pkg::pos_t'(COLS - 1));
        col_wrap = (col == mf_pkg::pos_t'(COLS - 1));
        last_pix = col_wrap && (row == mf_pkg::pos_t'(ROWS - 1));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mf_pkg::FILL0;
            row   <= '0;
            col   <= '0;
            ctl_o <= '0;
        end else begin
            // strobes only last one cycle
            ctl_o.valid <= 1'b0;
            ctl_o.last  <= 1'b0;
            if (col_valid_i) begin
                unique case (state)
                    mf_pkg::FILL0: state <= mf_pkg::FILL1;
                    mf_pkg::FILL1: state <= mf_pkg::RUN;
                    default: begin
                        ctl_o.valid  <= 1'b1;
                        ctl_o.row_ok <= row_ok;
                        ctl_o.col_ok <= col_ok;
                        ctl_o.last   <= last_pix;
                        if (col_wrap) begin
                            col <= '0;
                            if (last_pix) begin
                                // frame complete, next slice starts warm-up again
                                row   <= '0;
                                state <= mf_pkg::FILL0;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/mf_window_shift.sv
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_window_shift (
    input  logic               clk,
    input  logic               rst,
    input  logic               col_valid_i,
    input  mf_pkg::col_slice_t col_i,
    output mf_pkg::window_t    win_o
);

    localparam int NEWEST = `MF_WIN - 1;

    mf_pkg::window_t win_q;

    // columns move one place towards col[0] per accepted slice,
    // the incoming slice always lands in the newest column
    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= '0;
        end else if (col_valid_i) begin
            for (int k = 0; k < NEWEST; k++) begin
                win_q.col[k] <= win_q.col[k+1];
            end
            win_q.col[NEWEST] <= col_i;
        end
    end

    // columns past a line end keep stale data here,
    // the mask stage zeroes them
    assign win_o = win_q;

endmodule

//--- hw/mf_window_top.sv
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_window_top #(
    parameter int ROWS = `MF_ROWS_DEF,
    parameter int COLS = `MF_COLS_DEF
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               col_valid_i,
    input  mf_pkg::col_slice_t col_i,
    output logic               win_valid_o,
    output mf_pkg::window_t    win_o,
    output logic               frame_done_o
);

    mf_pkg::window_t  win_raw;
    mf_pkg::win_ctl_t win_ctl;

    // decode and shift update on the same accepting edge,
    // so win_raw and win_ctl always describe one window
    mf_pos_decode #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_mf_pos_decode (
        .clk         (clk),
        .rst         (rst),
        .col_valid_i (col_valid_i),
        .ctl_o       (win_ctl)
    );

    mf_window_shift u_mf_window_shift (
        .clk         (clk),
        .rst         (rst),
        .col_valid_i (col_valid_i),
        .col_i       (col_i),
        .win_o       (win_raw)
    );

    mf_pad_mask u_mf_pad_mask (
        .clk          (clk),
        .rst          (rst),
        .ctl_i        (win_ctl),
        .win_i        (win_raw),
        .win_valid_o  (win_valid_o),
        .win_o        (win_o),
        .frame_done_o (frame_done_o)
    );

endmodule

//--- include/mf_consts.svh
`ifndef MF_CONSTS_SVH
`define MF_CONSTS_SVH

// window side, odd so that a centre pixel exists
`define MF_WIN 5

// pixel width in bits
`define MF_PIX_W 8

// row and column counter width, covers up to 1023 lines or columns
`define MF_POS_W 10

// default image size
`define MF_ROWS_DEF 480
`define MF_COLS_DEF 640

`endif

//--- sim/mf_window_chk.sv
`timescale 1ns/1ps

module mf_window_chk (
    input logic clk,
    input logic rst,
    input logic col_valid_i,
    input logic win_valid_i,
    input logic frame_done_i
);

    int fail_cnt = 0;

    // an edge taken in reset leaves the output strobe low
    a_reset_quiet: assert property (@(posedge clk) rst |=> !win_valid_i)
        else begin
            $error("win_valid_o high after a reset edge");
            fail_cnt = fail_cnt + 1;
        end

    a_done_with_win: assert property (@(posedge clk) disable iff (rst)
        frame_done_i |-> win_valid_i)
        else begin
            $error("frame_done_o high without win_valid_o");
            fail_cnt = fail_cnt + 1;
        end

    // two edges of latency from an accepted slice to its window
    a_win_has_slice: assert property (@(posedge clk) disable iff (rst)
        win_valid_i |-> $past(col_valid_i, 2))
        else begin
            $error("win_valid_o without a slice two edges earlier");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind mf_window_top mf_window_chk u_mf_window_chk (
    .clk          (clk),
    .rst          (rst),
    .col_valid_i  (col_valid_i),
    .win_valid_i  (win_valid_o),
    .frame_done_i (frame_done_o)
);

//--- sim/mf_window_scoreboard.sv
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_window_scoreboard #(
    parameter int ROWS = 6,
    parameter int COLS = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               col_valid_i,
    input  mf_pkg::col_slice_t col_i,
    input  logic               win_valid_i,
    input  mf_pkg::window_t    win_i,
    input  logic               frame_done_i,
    output int                 err_cnt_o,
    output int                 win_cnt_o,
    output int                 frame_cnt_o,
    output int                 pending_o
);

    localparam int HALF = `MF_WIN / 2;
    localparam int FRAME_WINS = ROWS * COLS;

    // hist[4] is the newest accepted slice
    mf_pkg::col_slice_t hist [`MF_WIN];
    int                 slice_cnt;
    mf_pkg::window_t    exp_win_q [$];
    logic               exp_last_q [$];

    initial begin
        err_cnt_o   = 0;
        win_cnt_o   = 0;
        frame_cnt_o = 0;
        pending_o   = 0;
        slice_cnt   = 0;
        for (int k = 0; k < `MF_WIN; k++) begin
            hist[k] = '0;
        end
    end

    // pixel (i, j) comes from image row r+i-2 and column c+j-2, zero outside
    function automatic mf_pkg::window_t expected_window(input int r, input int c);
        mf_pkg::window_t w;
        int              img_r;
        int              img_c;
        for (int j = 0; j < `MF_WIN; j++) begin
            for (int i = 0; i < `MF_WIN; i++) begin
                img_r = r + i - HALF;
                img_c = c + j - HALF;
                if (img_r < 0 || img_r >= ROWS || img_c < 0 || img_c >= COLS) begin
                    w.col[j].px[i] = '0;
                end else begin
                    w.col[j].px[i] = hist[j].px[i];
                end
            end
        end
        return w;
    endfunction

    always @(posedge clk) begin
        mf_pkg::window_t exp_win;
        logic            exp_last;
        int              w;
        // outputs seen here were registered at the previous edge
        if (frame_done_i && !win_valid_i) begin
            $display("frame_done_o raised without a window");
            err_cnt_o++;
        end
        if (win_valid_i) begin
            if (exp_win_q.size() == 0) begin
                $display("window produced when none was expected");
                err_cnt_o++;
            end else begin
                exp_win  = exp_win_q.pop_front();
                exp_last = exp_last_q.pop_front();
                if (win_i !== exp_win) begin
                    $display("FAIL win_o exp %h got %h", exp_win, win_i);
                    err_cnt_o++;
                end
                if (frame_done_i !== exp_last) begin
                    $display("FAIL frame_done_o exp %h got %h", exp_last, frame_done_i);
                    err_cnt_o++;
                end
                win_cnt_o++;
            end
            if (frame_done_i) begin
                frame_cnt_o++;
            end
        end
        if (rst) begin
            slice_cnt = 0;
            exp_win_q.delete();
            exp_last_q.delete();
            for (int k = 0; k < `MF_WIN; k++) begin
                hist[k] = '0;
            end
        end else if (col_valid_i) begin
            for (int k = 0; k < `MF_WIN - 1; k++) begin
                hist[k] = hist[k+1];
            end
            hist[`MF_WIN-1] = col_i;
            // slices 0 and 1 of a frame are warm-up
            if (slice_cnt >= 2) begin
                w = slice_cnt - 2;
                exp_win_q.push_back(expected_window(w / COLS, w % COLS));
                exp_last_q.push_back(w == FRAME_WINS - 1);
            end
            if (slice_cnt == FRAME_WINS + 1) begin
                slice_cnt = 0;
            end else begin
                slice_cnt++;
            end
        end
        pending_o = exp_win_q.size();
    end

endmodule

//--- sim/mf_window_tb.sv
`timescale 1ns/1ps
`include "mf_consts.svh"

module mf_window_tb;

    localparam int ROWS = 6;
    localparam int COLS = 7;
    localparam int FRAME_SLICES = ROWS * COLS + 2;
    localparam int FULL_FRAMES = 5;
    // five full frames plus the one cut short by the mid-frame reset
    localparam int TIMEOUT_CYCLES = (FULL_FRAMES + 1) * FRAME_SLICES * 2 + 200;

    logic               clk;
    logic               rst;
    logic               col_valid_i;
    mf_pkg::col_slice_t col_i;
    logic               win_valid_o;
    mf_pkg::window_t    win_o;
    logic               frame_done_o;

    int sb_err_cnt;
    int sb_win_cnt;
    int sb_frame_cnt;
    int sb_pending;
    int chk_err_cnt;
    int cycle_cnt = 0;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    mf_window_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_mf_window_top (
        .clk          (clk),
        .rst          (rst),
        .col_valid_i  (col_valid_i),
        .col_i        (col_i),
        .win_valid_o  (win_valid_o),
        .win_o        (win_o),
        .frame_done_o (frame_done_o)
    );

    mf_window_scoreboard #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_mf_window_scoreboard (
        .clk          (clk),
        .rst          (rst),
        .col_valid_i  (col_valid_i),
        .col_i        (col_i),
        .win_valid_i  (win_valid_o),
        .win_i        (win_o),
        .frame_done_i (frame_done_o),
        .err_cnt_o    (sb_err_cnt),
        .win_cnt_o    (sb_win_cnt),
        .frame_cnt_o  (sb_frame_cnt),
        .pending_o    (sb_pending)
    );

    function automatic mf_pkg::col_slice_t random_slice();
        mf_pkg::col_slice_t s;
        for (int k = 0; k < `MF_WIN; k++) begin
            s.px[k] = mf_pkg::pixel_t'($urandom);
        end
        return s;
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst         = 1'b1;
        col_valid_i = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    // strobe high three cycles out of four on average, pixels random either way
    task automatic send_slices(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            col_i = random_slice();
            if ($urandom_range(3) != 0) begin
                col_valid_i = 1'b1;
                sent++;
            end else begin
                col_valid_i = 1'b0;
            end
        end
    endtask

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles with %0d of %0d frames done",
                 cycle_cnt, sb_frame_cnt, FULL_FRAMES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        col_valid_i = 1'b0;
        col_i       = '0;
        void'($urandom(32'he46e24f0));
        apply_reset();
        // four frames back to back, warm-up restarts inside the stream
        send_slices(4 * FRAME_SLICES);
        // half a frame, then reset drops whatever is in flight
        send_slices(FRAME_SLICES / 2);
        apply_reset();
        send_slices(FRAME_SLICES);
        @(negedge clk);
        col_valid_i = 1'b0;
        wait (sb_frame_cnt == FULL_FRAMES);
        repeat (4) @(negedge clk);
        chk_err_cnt = u_mf_window_top.u_mf_window_chk.fail_cnt;
        if (sb_pending != 0) begin
            $display("run ended with %0d expected windows never produced", sb_pending);
        end
        $display("errors: scoreboard %0d, assertions %0d, missing windows %0d (%0d windows)",
                 sb_err_cnt, chk_err_cnt, sb_pending, sb_win_cnt);
        if (sb_err_cnt == 0 && chk_err_cnt == 0 && sb_pending == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
hw/mf_pkg.sv
hw/mf_pos_decode.sv
hw/mf_window_shift.sv
hw/mf_pad_mask.sv
hw/mf_window_top.sv
sim/mf_window_chk.sv
sim/mf_window_scoreboard.sv
sim/mf_window_tb.sv
